//--- files.f
hw/dbg_jsp_fifo_pkg.sv
hw/dbg_jsp_reg_pkg.sv
hw/dbg_jsp_bytefifo.sv
hw/dbg_jsp_syncflop.sv
hw/dbg_jsp_syncreg.sv
hw/dbg_jsp_tck_port.sv
hw/dbg_jsp_apb_bridge.sv
hw/dbg_jsp_top.sv
tests/dbg_jsp_tb.sv

//--- hw/dbg_jsp_apb_bridge.sv
// PCLK-domain core of the JTAG serial port
// Strobe and count crossings, the two byte FIFOs
// Read FSM (APB-to-JTAG FIFO) and write FSM (JTAG-to-APB FIFO)
// 16550 registers, APB response and interrupt
`timescale 1ns/10ps

module dbg_jsp_apb_bridge (
  input  logic                              PCLK,
  input  logic                              PRESETn,
  input  logic                              tck_i,
  input  logic                              wen_toggle_i,
  input  logic                              ren_toggle_i,
  input  logic [7:0]                        wdata_i,
  output logic [7:0]                        rdata_o,
  output dbg_jsp_fifo_pkg::jsp_tck_status_t tck_status_o,
  input  dbg_jsp_reg_pkg::apb_req_t         apb_req_i,
  output dbg_jsp_reg_pkg::apb_rsp_t         apb_rsp_o,
  output logic                              int_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  dbg_jsp_fifo_pkg::jsp_rd_state_e rd_state_q;
  dbg_jsp_fifo_pkg::jsp_rd_state_e rd_state_d;
  dbg_jsp_fifo_pkg::jsp_wr_state_e wr_state_q;
  dbg_jsp_fifo_pkg::jsp_wr_state_e wr_state_d;

  // FIFO status
  dbg_jsp_fifo_pkg::jsp_count_t a2j_avail;
  dbg_jsp_fifo_pkg::jsp_count_t a2j_free;
  dbg_jsp_fifo_pkg::jsp_count_t j2a_avail;
  dbg_jsp_fifo_pkg::jsp_count_t j2a_free;
  dbg_jsp_fifo_pkg::jsp_count_t tck_avail;
  dbg_jsp_fifo_pkg::jsp_count_t tck_free;
  logic [7:0]                   a2j_head;
  logic [7:0]                   j2a_head;

  // FSM outputs
  logic a2j_en;
  logic a2j_push;
  logic j2a_en;
  logic j2a_push;
  logic wen_clr;
  logic ren_clr;
  logic rdata_en;
  logic r_ack;
  logic w_ack;

  // Requests into the FSMs
  logic wen_req;
  logic ren_req;
  logic pop_req;
  logic fifo_wr;
  logic fifo_rd;
  logic wr_pend_q;
  logic rd_pend_q;

  // APB decode and 16550 registers
  logic       setup;
  logic       acc_wr;
  logic       fifo_sel;
  logic       wr_setup;
  logic       rd_setup;
  logic       iir_read;
  logic       fcr_wr;
  logic       reg_ack_q;
  logic [3:0] ier_q;
  logic [7:0] lcr_q;
  logic [7:0] scr_q;
  logic       thr_arm_q;
  logic       a2j_not_full;
  logic       j2a_not_empty;
  logic       a2j_going_empty;
  logic [7:0] iir;
  logic [7:0] lsr;
  logic [7:0] prdata;

  ////////////////////////////////////////////////////////////////////////////
  // Clock domain crossings
  ////////////////////////////////////////////////////////////////////////////

  // JTAG write strobe
  dbg_jsp_syncflop i_wen_sync (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .toggle_i(wen_toggle_i),
    .clr_i   (wen_clr),
    .req_o   (wen_req)
  );

  // JTAG read strobe
  dbg_jsp_syncflop i_ren_sync (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .toggle_i(ren_toggle_i),
    .clr_i   (ren_clr),
    .req_o   (ren_req)
  );

  // Bytes the debugger can read
  dbg_jsp_syncreg i_avail_sync (
    .PCLK   (PCLK),
    .tck_i  (tck_i),
    .PRESETn(PRESETn),
    .count_i(a2j_avail),
    .count_o(tck_avail)
  );

  // Space the debugger can write into
  dbg_jsp_syncreg i_free_sync (
    .PCLK   (PCLK),
    .tck_i  (tck_i),
    .PRESETn(PRESETn),
    .count_i(j2a_free),
    .count_o(tck_free)
  );

  assign tck_status_o = '{bytes_avail: tck_avail, bytes_free: tck_free};

  ////////////////////////////////////////////////////////////////////////////
  // FIFOs
  ////////////////////////////////////////////////////////////////////////////

  // APB writes, JTAG reads
  dbg_jsp_bytefifo i_a2j_fifo (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .clr_i        (fcr_wr & apb_req_i.pwdata[2]),
    .en_i         (a2j_en),
    .push_i       (a2j_push),
    .data_i       (apb_req_i.pwdata),
    .data_o       (a2j_head),
    .bytes_avail_o(a2j_avail),
    .bytes_free_o (a2j_free)
  );

  // JTAG writes, APB reads
  dbg_jsp_bytefifo i_j2a_fifo (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .clr_i        (fcr_wr & apb_req_i.pwdata[1]),
    .en_i         (j2a_en),
    .push_i       (j2a_push),
    .data_i       (wdata_i),
    .data_o       (j2a_head),
    .bytes_avail_o(j2a_avail),
    .bytes_free_o (j2a_free)
  );

  assign a2j_not_full  = (a2j_free != '0);
  assign j2a_not_empty = (j2a_avail != '0);
  // JTAG pop only when there is something to give
  assign pop_req       = ren_req & (a2j_avail != '0);

  // Byte offered to the debugger
  always_ff @(posedge PCLK) begin
    if (rdata_en) begin
      rdata_o <= a2j_head;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB decode and pending FIFO requests
  ////////////////////////////////////////////////////////////////////////////

  assign setup    = apb_req_i.psel & ~apb_req_i.penable;
  assign acc_wr   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  // LCR[7] turns offset 0 into a plain register slot
  assign fifo_sel = (apb_req_i.paddr == dbg_jsp_reg_pkg::REG_DATA) & ~lcr_q[7];
  assign wr_setup = setup & fifo_sel & apb_req_i.pwrite;
  assign rd_setup = setup & fifo_sel & ~apb_req_i.pwrite;
  assign fcr_wr   = acc_wr & (apb_req_i.paddr == dbg_jsp_reg_pkg::REG_IIR_FCR);
  assign iir_read = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite &
                    (apb_req_i.paddr == dbg_jsp_reg_pkg::REG_IIR_FCR);

  // Held from setup until the FSM acks, so a busy FSM never loses it
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      wr_pend_q <= 1'b0;
      rd_pend_q <= 1'b0;
      reg_ack_q <= 1'b0;
    end else begin
      wr_pend_q <= (wr_pend_q | wr_setup) & ~r_ack;
      rd_pend_q <= (rd_pend_q | rd_setup) & ~w_ack;
      // Register slots complete in the first access cycle
      reg_ack_q <= setup & ~fifo_sel;
    end
  end

  assign fifo_wr = wr_setup | wr_pend_q;
  assign fifo_rd = rd_setup | rd_pend_q;

  ////////////////////////////////////////////////////////////////////////////
  // Read FSM, APB pushes against JTAG pops
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      rd_state_q <= dbg_jsp_fifo_pkg::RD_IDLE;
      wr_state_q <= dbg_jsp_fifo_pkg::WR_IDLE;
    end else begin
      rd_state_q <= rd_state_d;
      wr_state_q <= wr_state_d;
    end
  end

  always_comb begin
    rd_state_d = dbg_jsp_fifo_pkg::RD_IDLE;
    a2j_en     = 1'b0;
    a2j_push   = 1'b0;
    ren_clr    = 1'b0;
    rdata_en   = 1'b0;
    r_ack      = 1'b0;
    case (rd_state_q)
      dbg_jsp_fifo_pkg::RD_PUSH: begin
        a2j_en   = 1'b1;
        a2j_push = 1'b1;
        r_ack    = 1'b1;
        // First byte into an empty FIFO becomes the new head
        if (a2j_avail == '0) begin
          rd_state_d = dbg_jsp_fifo_pkg::RD_LATCH;
        end else if (pop_req) begin
          rd_state_d = dbg_jsp_fifo_pkg::RD_POP;
        end
      end
      dbg_jsp_fifo_pkg::RD_POP: begin
        a2j_en     = 1'b1;
        ren_clr    = 1'b1;
        rd_state_d = dbg_jsp_fifo_pkg::RD_LATCH;
      end
      default: begin
        // Idle and latch share the arbitration
        rdata_en = (rd_state_q == dbg_jsp_fifo_pkg::RD_LATCH);
        if (fifo_wr) begin
          rd_state_d = dbg_jsp_fifo_pkg::RD_PUSH;
        end else if (pop_req) begin
          rd_state_d = dbg_jsp_fifo_pkg::RD_POP;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write FSM, JTAG pushes against APB pops
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    wr_state_d = dbg_jsp_fifo_pkg::WR_IDLE;
    j2a_en     = 1'b0;
    j2a_push   = 1'b0;
    wen_clr    = 1'b0;
    w_ack      = 1'b0;
    case (wr_state_q)
      dbg_jsp_fifo_pkg::WR_PUSH: begin
        j2a_en   = 1'b1;
        j2a_push = 1'b1;
        wen_clr  = 1'b1;
        if (fifo_rd) begin
          wr_state_d = dbg_jsp_fifo_pkg::WR_POP;
        end
      end
      dbg_jsp_fifo_pkg::WR_POP: begin
        j2a_en = 1'b1;
        w_ack  = 1'b1;
        if (wen_req) begin
          wr_state_d = dbg_jsp_fifo_pkg::WR_PUSH;
        end
      end
      default: begin
        // APB read has priority
        if (fifo_rd) begin
          wr_state_d = dbg_jsp_fifo_pkg::WR_POP;
        end else if (wen_req) begin
          wr_state_d = dbg_jsp_fifo_pkg::WR_PUSH;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // 16550 registers
  ////////////////////////////////////////////////////////////////////////////

  // Writes land at the access edge
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      ier_q <= '0;
      lcr_q <= '0;
      scr_q <= '0;
    end else if (acc_wr) begin
      case (apb_req_i.paddr)
        dbg_jsp_reg_pkg::REG_IER: begin
          if (!lcr_q[7]) begin
            ier_q <= apb_req_i.pwdata[3:0];
          end
        end
        dbg_jsp_reg_pkg::REG_LCR: lcr_q <= apb_req_i.pwdata;
        dbg_jsp_reg_pkg::REG_SCR: scr_q <= apb_req_i.pwdata;
        default: begin
        end
      endcase
    end
  end

  // Transmit arm, set on a FIFO write or when the JTAG side takes the last byte
  assign a2j_going_empty = a2j_en & ~a2j_push & (a2j_avail == 4'd1);

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      thr_arm_q <= 1'b0;
    end else if (wr_setup || a2j_going_empty) begin
      thr_arm_q <= 1'b1;
    end else if (iir_read && !j2a_not_empty) begin
      thr_arm_q <= 1'b0;
    end
  end

  // Received data outranks transmit empty
  always_comb begin
    if (j2a_not_empty) begin
      iir = dbg_jsp_reg_pkg::iir_rx_data;
    end else if (thr_arm_q && a2j_not_full) begin
      iir = dbg_jsp_reg_pkg::iir_thr_empty;
    end else begin
      iir = dbg_jsp_reg_pkg::iir_none;
    end
  end

  always_comb begin
    lsr                                = '0;
    lsr[dbg_jsp_reg_pkg::lsr_dr_bit]   = j2a_not_empty;
    lsr[dbg_jsp_reg_pkg::lsr_thre_bit] = a2j_not_full;
    lsr[dbg_jsp_reg_pkg::lsr_temt_bit] = a2j_not_full;
  end

  // Read data mux
  always_comb begin
    case (apb_req_i.paddr)
      dbg_jsp_reg_pkg::REG_DATA:    prdata = j2a_head;
      dbg_jsp_reg_pkg::REG_IER:     prdata = {4'h0, ier_q};
      dbg_jsp_reg_pkg::REG_IIR_FCR: prdata = iir;
      dbg_jsp_reg_pkg::REG_LCR:     prdata = lcr_q;
      dbg_jsp_reg_pkg::REG_MCR:     prdata = dbg_jsp_reg_pkg::mcr_value;
      dbg_jsp_reg_pkg::REG_LSR:     prdata = lsr;
      dbg_jsp_reg_pkg::REG_MSR:     prdata = dbg_jsp_reg_pkg::msr_value;
      default:                      prdata = scr_q;
    endcase
  end

  assign apb_rsp_o = '{prdata: prdata, pready: r_ack | w_ack | reg_ack_q, pslverr: 1'b0};

  assign int_o = (ier_q[0] & j2a_not_empty) | (ier_q[1] & thr_arm_q & a2j_not_full);

endmodule

//--- hw/dbg_jsp_bytefifo.sv
// Byte FIFO of the JTAG serial port
// Circular buffer with one enable, push or pop per cycle
// Head shown combinationally, occupancy and free counts
`timescale 1ns/10ps

module dbg_jsp_bytefifo (
  input  logic                         PCLK,
  input  logic                         PRESETn,
  input  logic                         clr_i,
  input  logic                         en_i,
  input  logic                         push_i,
  input  logic [7:0]                   data_i,
  output logic [7:0]                   data_o,
  output dbg_jsp_fifo_pkg::jsp_count_t bytes_avail_o,
  output dbg_jsp_fifo_pkg::jsp_count_t bytes_free_o
);

  logic [7:0]                             mem_q [dbg_jsp_fifo_pkg::jsp_depth];
  logic [dbg_jsp_fifo_pkg::jsp_ptr_w-1:0] wr_ptr_q;
  logic [dbg_jsp_fifo_pkg::jsp_ptr_w-1:0] rd_ptr_q;
  dbg_jsp_fifo_pkg::jsp_count_t           count_q;
  dbg_jsp_fifo_pkg::jsp_count_t           full_count;
  logic                                   do_push;
  logic                                   do_pop;

  assign full_count = dbg_jsp_fifo_pkg::jsp_count_t'(dbg_jsp_fifo_pkg::jsp_depth);

  // Push into a full FIFO is dropped, pop from empty keeps the stale head
  assign do_push = en_i & push_i & (count_q != full_count);
  assign do_pop  = en_i & ~push_i & (count_q != '0);

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        count_q  <= count_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        count_q  <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge PCLK) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o        = mem_q[rd_ptr_q];
  assign bytes_avail_o = count_q;
  assign bytes_free_o  = full_count - count_q;

endmodule

//--- hw/dbg_jsp_fifo_pkg.sv
// FIFO-side definitions of the JTAG serial port
// FIFO depth, pointer width and occupancy count type
// Status struct seen by the TCK side
// State encodings of the two FIFO FSMs
package dbg_jsp_fifo_pkg;

  // Both byte FIFOs hold 8 entries
  localparam int jsp_depth = 8;
  localparam int jsp_ptr_w = $clog2(jsp_depth);

  // Occupancy 0 to 8 needs one bit more than the pointers
  typedef logic [3:0] jsp_count_t;

  // Status returned to the debugger, 8 bits
  typedef struct packed {
    jsp_count_t bytes_avail;
    jsp_count_t bytes_free;
  } jsp_tck_status_t;

  // APB-to-JTAG FIFO FSM
  typedef enum logic [1:0] {
    RD_IDLE  = 2'b11,
    RD_PUSH  = 2'b10,
    RD_POP   = 2'b01,
    RD_LATCH = 2'b00
  } jsp_rd_state_e;

  // JTAG-to-APB FIFO FSM
  typedef enum logic [1:0] {
    WR_IDLE = 2'b10,
    WR_PUSH = 2'b01,
    WR_POP  = 2'b00
  } jsp_wr_state_e;

endpackage

//--- hw/dbg_jsp_reg_pkg.sv
// APB-side definitions of the JTAG serial port
// Register offsets of the cut-down 16550 map
// APB request and response structs
// Fixed register values, IIR codes and LSR bit positions
package dbg_jsp_reg_pkg;

  // 16550 register offsets
  typedef enum logic [2:0] {
    REG_DATA    = 3'd0,
    REG_IER     = 3'd1,
    REG_IIR_FCR = 3'd2,
    REG_LCR     = 3'd3,
    REG_MCR     = 3'd4,
    REG_LSR     = 3'd5,
    REG_MSR     = 3'd6,
    REG_SCR     = 3'd7
  } jsp_reg_addr_e;

  // APB request, 14 bits
  typedef struct packed {
    logic          psel;
    logic          penable;
    logic          pwrite;
    jsp_reg_addr_e paddr;
    logic [7:0]    pwdata;
  } apb_req_t;

  // APB response, 10 bits
  typedef struct packed {
    logic [7:0] prdata;
    logic       pready;
    logic       pslverr;
  } apb_rsp_t;

  // Modem registers are constants
  localparam logic [7:0] msr_value = 8'h0B;
  localparam logic [7:0] mcr_value = 8'h00;

  // IIR interrupt identification codes
  localparam logic [7:0] iir_rx_data   = 8'h04;
  localparam logic [7:0] iir_thr_empty = 8'h02;
  localparam logic [7:0] iir_none      = 8'h01;

  // LSR bit positions
  localparam int lsr_dr_bit   = 0;
  localparam int lsr_thre_bit = 5;
  localparam int lsr_temt_bit = 6;

endpackage

//--- hw/dbg_jsp_syncflop.sv
// Toggle-to-request synchronizer into PCLK
// Two-flop synchronizer, edge detect and sticky request
`timescale 1ns/10ps

module dbg_jsp_syncflop (
  input  logic PCLK,
  input  logic PRESETn,
  input  logic toggle_i,
  input  logic clr_i,
  output logic req_o
);

  logic sync1_q;
  logic sync2_q;
  logic prev_q;
  logic hold_q;
  logic edge_det;

  // Any change of the synchronized toggle is one strobe
  assign edge_det = sync2_q ^ prev_q;

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      prev_q  <= 1'b0;
      hold_q  <= 1'b0;
    end else begin
      sync1_q <= toggle_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // A fresh edge wins over a clear in the same cycle
      hold_q  <= edge_det | (hold_q & ~clr_i);
    end
  end

  // Edge shows up one cycle early so the FSM can react at once
  assign req_o = hold_q | edge_det;

endmodule

//--- hw/dbg_jsp_syncreg.sv
// Occupancy count synchronizer from PCLK into TCK
// Holding register with a toggle request and toggle acknowledge
`timescale 1ns/10ps

module dbg_jsp_syncreg (
  input  logic                         PCLK,
  input  logic                         tck_i,
  input  logic                         PRESETn,
  input  dbg_jsp_fifo_pkg::jsp_count_t count_i,
  output dbg_jsp_fifo_pkg::jsp_count_t count_o
);

  // PCLK side
  dbg_jsp_fifo_pkg::jsp_count_t hold_q;
  logic                         req_tgl_q;
  logic                         ack_s1_q;
  logic                         ack_s2_q;
  // TCK side
  logic                         req_s1_q;
  logic                         req_s2_q;
  logic                         ack_tgl_q;

  // Hold only reloads once TCK has taken the last value
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      hold_q    <= '0;
      req_tgl_q <= 1'b0;
      ack_s1_q  <= 1'b0;
      ack_s2_q  <= 1'b0;
    end else begin
      ack_s1_q <= ack_tgl_q;
      ack_s2_q <= ack_s1_q;
      if ((ack_s2_q == req_tgl_q) && (count_i != hold_q)) begin
        hold_q    <= count_i;
        req_tgl_q <= ~req_tgl_q;
      end
    end
  end

  // Hold is stable while the request toggle is in flight
  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      req_s1_q  <= 1'b0;
      req_s2_q  <= 1'b0;
      ack_tgl_q <= 1'b0;
      count_o   <= '0;
    end else begin
      req_s1_q <= req_tgl_q;
      req_s2_q <= req_s1_q;
      if (req_s2_q != ack_tgl_q) begin
        count_o   <= hold_q;
        ack_tgl_q <= req_s2_q;
      end
    end
  end

endmodule

//--- hw/dbg_jsp_tck_port.sv
// TCK-domain front end of the JTAG serial port
// Write and read toggle flops, write data register
`timescale 1ns/10ps

module dbg_jsp_tck_port (
  input  logic       tck_i,
  input  logic       PRESETn,
  input  logic       wr_strobe_i,
  input  logic       rd_strobe_i,
  input  logic [7:0] data_i,
  output logic       wen_toggle_o,
  output logic       ren_toggle_o,
  output logic [7:0] wdata_o
);

  // Each strobe flips its toggle once
  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      wen_toggle_o <= 1'b0;
      ren_toggle_o <= 1'b0;
    end else begin
      if (wr_strobe_i) begin
        wen_toggle_o <= ~wen_toggle_o;
      end
      if (rd_strobe_i) begin
        ren_toggle_o <= ~ren_toggle_o;
      end
    end
  end

  // Write byte, quasi-static until the PCLK side has pushed it
  always_ff @(posedge tck_i) begin
    if (wr_strobe_i) begin
      wdata_o <= data_i;
    end
  end

endmodule

//--- hw/dbg_jsp_top.sv
// JTAG serial port subsystem
// TCK-side byte port joined to the APB 16550 bridge
`timescale 1ns/10ps

module dbg_jsp_top (
  input  logic                              PCLK,
  input  logic                              PRESETn,
  input  logic                              tck_i,
  // Debugger byte port
  input  logic                              wr_strobe_i,
  input  logic                              rd_strobe_i,
  input  logic [7:0]                        data_i,
  output logic [7:0]                        data_o,
  output dbg_jsp_fifo_pkg::jsp_tck_status_t tck_status_o,
  // APB slave
  input  dbg_jsp_reg_pkg::apb_req_t         apb_req_i,
  output dbg_jsp_reg_pkg::apb_rsp_t         apb_rsp_o,
  output logic                              int_o
);

  // Quasi-static signals crossing from TCK into PCLK
  logic       wen_toggle;
  logic       ren_toggle;
  logic [7:0] wdata;

  dbg_jsp_tck_port i_tck_port (
    .tck_i       (tck_i),
    .PRESETn     (PRESETn),
    .wr_strobe_i (wr_strobe_i),
    .rd_strobe_i (rd_strobe_i),
    .data_i      (data_i),
    .wen_toggle_o(wen_toggle),
    .ren_toggle_o(ren_toggle),
    .wdata_o     (wdata)
  );

  dbg_jsp_apb_bridge i_bridge (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .tck_i       (tck_i),
    .wen_toggle_i(wen_toggle),
    .ren_toggle_i(ren_toggle),
    .wdata_i     (wdata),
    .rdata_o     (data_o),
    .tck_status_o(tck_status_o),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .int_o       (int_o)
  );

endmodule

//--- tests/dbg_jsp_tb.sv
// Testbench of the JTAG serial port subsystem
// PCLK and TCK generation, reset sequence
// APB and debugger driver tasks, register and status polling
// Compare tasks, stimulus table reader and watchdog
`timescale 1ns/10ps

module dbg_jsp_tb;

  logic                              PCLK;
  logic                              PRESETn;
  logic                              tck;
  logic                              wr_strobe;
  logic                              rd_strobe;
  logic [7:0]                        tck_wdata;
  logic [7:0]                        tck_rdata;
  dbg_jsp_fifo_pkg::jsp_tck_status_t tck_status;
  dbg_jsp_reg_pkg::apb_req_t         apb_req;
  dbg_jsp_reg_pkg::apb_rsp_t         apb_rsp;
  logic                              irq;

  // Stimulus table, one entry per command line
  string       op_q[$];
  logic [7:0]  arg_q[$];
  logic [7:0]  exp_q[$];
  bit          table_loaded;
  int unsigned seed_ret;

  dbg_jsp_top i_dut (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .tck_i       (tck),
    .wr_strobe_i (wr_strobe),
    .rd_strobe_i (rd_strobe),
    .data_i      (tck_wdata),
    .data_o      (tck_rdata),
    .tck_status_o(tck_status),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .int_o       (irq)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clocks
  ////////////////////////////////////////////////////////////////////////////

  // PCLK 40 ns
  initial begin
    PCLK = 1'b0;
    forever #20 PCLK = ~PCLK;
  end

  // TCK 100 ns, unrelated to PCLK
  initial begin
    tck = 1'b0;
    forever #50 tck = ~tck;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure handling and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_rdata(input logic [2:0] addr, input dbg_jsp_reg_pkg::apb_rsp_t rsp,
                             input logic [7:0] exp_val);
    if (rsp.prdata !== exp_val) begin
      $display("** Error at %0t: offset %0d read 0x%02h, expected 0x%02h",
               $time, addr, rsp.prdata, exp_val);
      stop_run();
    end
  endtask

  // The slave never signals an error
  task automatic check_slverr(input logic [2:0] addr,
                              input dbg_jsp_reg_pkg::apb_rsp_t rsp);
    if (rsp.pslverr !== 1'b0) begin
      $display("** Error at %0t: offset %0d returned PSLVERR %b, expected 0",
               $time, addr, rsp.pslverr);
      stop_run();
    end
  endtask

  task automatic check_tck_data(input logic [7:0] got, input logic [7:0] exp_val);
    if (got !== exp_val) begin
      $display("** Error at %0t: debugger byte 0x%02h, expected 0x%02h",
               $time, got, exp_val);
      stop_run();
    end
  endtask

  task automatic check_status(input dbg_jsp_fifo_pkg::jsp_tck_status_t got,
                              input dbg_jsp_fifo_pkg::jsp_tck_status_t exp_val);
    if (got !== exp_val) begin
      $display("** Error at %0t: TCK status avail %0d free %0d, expected avail %0d free %0d",
               $time, got.bytes_avail, got.bytes_free,
               exp_val.bytes_avail, exp_val.bytes_free);
      stop_run();
    end
  endtask

  task automatic check_irq(input logic got, input logic exp_val);
    if (got !== exp_val) begin
      $display("** Error at %0t: int_o is %b, expected %b", $time, got, exp_val);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB side
  ////////////////////////////////////////////////////////////////////////////

  // One transfer, setup then access until PREADY
  task automatic apb_access(input bit wr, input logic [2:0] addr, input logic [7:0] wdata,
                            output dbg_jsp_reg_pkg::apb_rsp_t rsp);
    int waits;
    waits = 0;
    @(posedge PCLK);
    #2;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = dbg_jsp_reg_pkg::jsp_reg_addr_e'(addr);
    apb_req.pwdata  = wdata;
    @(posedge PCLK);
    #2;
    apb_req.penable = 1'b1;
    // PREADY sampled mid-cycle, away from both edges
    @(negedge PCLK);
    while (!apb_rsp.pready && (waits < 32)) begin
      waits++;
      @(negedge PCLK);
    end
    if (!apb_rsp.pready) begin
      $display("APB transfer to offset %0d never got PREADY", addr);
      stop_run();
    end
    rsp = apb_rsp;
    check_slverr(addr, rsp);
    @(posedge PCLK);
    #2;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  // Read a register until it matches, then compare
  task automatic poll_reg(input logic [2:0] addr, input logic [7:0] exp_val);
    dbg_jsp_reg_pkg::apb_rsp_t rsp;
    int tries;
    tries = 0;
    apb_access(1'b0, addr, 8'h00, rsp);
    while ((rsp.prdata !== exp_val) && (tries < 40)) begin
      tries++;
      apb_access(1'b0, addr, 8'h00, rsp);
    end
    check_rdata(addr, rsp, exp_val);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Debugger side
  ////////////////////////////////////////////////////////////////////////////

  // Counts are TCK flops, so look at them on the falling edge
  task automatic poll_status(input dbg_jsp_fifo_pkg::jsp_tck_status_t exp_val);
    int cycles;
    cycles = 0;
    @(negedge tck);
    while ((tck_status !== exp_val) && (cycles < 40)) begin
      cycles++;
      @(negedge tck);
    end
    check_status(tck_status, exp_val);
  endtask

  task automatic jtag_write(input logic [7:0] value);
    dbg_jsp_fifo_pkg::jsp_tck_status_t st;
    int cycles;
    cycles = 0;
    @(negedge tck);
    st = tck_status;
    // Strobe only into free space
    while ((st.bytes_free == '0) && (cycles < 40)) begin
      cycles++;
      @(negedge tck);
      st = tck_status;
    end
    if (st.bytes_free == '0) begin
      $display("Debugger write of 0x%02h found no free space", value);
      stop_run();
    end
    @(posedge tck);
    #2;
    tck_wdata = value;
    wr_strobe = 1'b1;
    @(posedge tck);
    #2;
    wr_strobe = 1'b0;
    // Free count drops once the byte is in the FIFO
    cycles = 0;
    @(negedge tck);
    while ((tck_status.bytes_free >= st.bytes_free) && (cycles < 40)) begin
      cycles++;
      @(negedge tck);
    end
    if (tck_status.bytes_free >= st.bytes_free) begin
      $display("Debugger write of 0x%02h never reached the FIFO", value);
      stop_run();
    end
  endtask

  task automatic jtag_read(input logic [7:0] exp_val);
    dbg_jsp_fifo_pkg::jsp_tck_status_t st;
    int cycles;
    cycles = 0;
    @(negedge tck);
    st = tck_status;
    while ((st.bytes_avail == '0) && (cycles < 40)) begin
      cycles++;
      @(negedge tck);
      st = tck_status;
    end
    if (st.bytes_avail == '0) begin
      $display("Debugger read found no byte available");
      stop_run();
    end
    // data_o already holds the byte the strobe consumes
    check_tck_data(tck_rdata, exp_val);
    @(posedge tck);
    #2;
    rd_strobe = 1'b1;
    @(posedge tck);
    #2;
    rd_strobe = 1'b0;
    // Pop and head latch are done by the time the count drops
    cycles = 0;
    @(negedge tck);
    while ((tck_status.bytes_avail >= st.bytes_avail) && (cycles < 40)) begin
      cycles++;
      @(negedge tck);
    end
    if (tck_status.bytes_avail >= st.bytes_avail) begin
      $display("Debugger read strobe never popped the FIFO");
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_table();
    int    fd;
    int    fields;
    string line;
    string op;
    logic [7:0] arg;
    logic [7:0] exp_val;
    fd = $fopen("tests/jsp_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tests/jsp_input.txt");
      stop_run();
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0) begin
        // Skip comments and blank lines
        if ((line.len() > 1) && (line[0] != "#")) begin
          fields = $sscanf(line, "%s %h %h", op, arg, exp_val);
          if (fields != 3) begin
            $display("Malformed stimulus line: %s", line);
            stop_run();
          end
          op_q.push_back(op);
          arg_q.push_back(arg);
          exp_q.push_back(exp_val);
        end
      end
    end
    $fclose(fd);
  endtask

  // Address 8 stands for int_o on R and for the TCK status on POLL
  task automatic run_op(input string op, input logic [7:0] arg, input logic [7:0] exp_val);
    dbg_jsp_reg_pkg::apb_rsp_t rsp;
    if (op == "W") begin
      apb_access(1'b1, arg[2:0], exp_val, rsp);
    end else if ((op == "R") && (arg == 8'h08)) begin
      @(negedge PCLK);
      check_irq(irq, exp_val[0]);
    end else if (op == "R") begin
      apb_access(1'b0, arg[2:0], 8'h00, rsp);
      check_rdata(arg[2:0], rsp, exp_val);
    end else if ((op == "POLL") && (arg == 8'h08)) begin
      poll_status(dbg_jsp_fifo_pkg::jsp_tck_status_t'(exp_val));
    end else if (op == "POLL") begin
      poll_reg(arg[2:0], exp_val);
    end else if (op == "TW") begin
      jtag_write(arg);
    end else if (op == "TR") begin
      jtag_read(exp_val);
    end else begin
      $display("Unknown opcode %s in the stimulus file", op);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int gap;
    PRESETn      = 1'b0;
    wr_strobe    = 1'b0;
    rd_strobe    = 1'b0;
    tck_wdata    = 8'h00;
    apb_req      = '0;
    table_loaded = 1'b0;
    seed_ret     = $urandom(32'hc474_5076);
    load_table();
    table_loaded = 1'b1;
    // Reset held for 8 PCLK cycles
    repeat (8) @(posedge PCLK);
    #2;
    PRESETn = 1'b1;
    for (int i = 0; i < op_q.size(); i++) begin
      run_op(op_q[i], arg_q[i], exp_q[i]);
      // Idle gap of 0 to 3 cycles
      gap = $urandom_range(3, 0);
      repeat (gap) @(posedge PCLK);
    end
    $display("TEST PASS");
    $finish;
  end

  // Budget of 200 PCLK cycles per command
  initial begin : watchdog
    wait (table_loaded);
    repeat (op_q.size() * 200 + 20) @(posedge PCLK);
    $display("The run timed out before all %0d commands finished", op_q.size());
    stop_run();
  end

endmodule

//--- tests/jsp_input.txt
# opcode, address or TCK byte, expected value or write data (hex)
# address 8 selects int_o for R and the TCK status {avail,free} for POLL
POLL 8 08
R 1 00
R 3 00
R 7 00
R 2 01
R 5 60
R 6 0B
R 4 00
R 8 00
W 7 C3
R 7 C3
W 1 FF
R 1 0F
W 3 83
R 3 83
W 1 05
R 1 0F
W 0 A5
W 3 03
R 3 03
POLL 8 08
W 1 00
W 0 11
W 0 22
W 0 33
POLL 8 38
TR 00 11
TR 00 22
TR 00 33
POLL 8 08
W 1 01
TW 41 00
TW 42 00
POLL 5 61
R 2 04
R 8 01
R 0 41
R 0 42
R 5 60
R 8 00
W 0 77
TW 88 00
POLL 8 17
W 2 06
POLL 8 08
R 5 60
R 2 02
R 2 01
W 1 02
R 8 00
W 0 5A
POLL 8 18
TR 00 5A
POLL 8 08
R 8 01
R 2 02
R 2 01
R 8 00
